//--- src/ht_pkg.sv
// hash-table write unit types: widths, field vectors, opcodes, states and channel structs
package ht_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int KEY_W          = 64;
	localparam int LEN_W          = 16;
	localparam int PTR_ADDR_W     = 32;
	localparam int VALPTR_W       = LEN_W + PTR_ADDR_W;
	localparam int ENTRY_W        = KEY_W + 2 * VALPTR_W;
	localparam int LINE_W         = 512;
	// three slots fill 480 bits, the top 32 bits of a line stay unused
	localparam int SLOTS_PER_LINE = 3;
	localparam int LINE_ADDR_W    = 21;
	localparam int TAG_W          = 88;

	typedef logic [KEY_W-1:0]       key_t;
	typedef logic [LEN_W-1:0]       len_t;
	typedef logic [PTR_ADDR_W-1:0]  ptr_addr_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [1:0]             slot_idx_t;
	typedef logic [15:0]            status_t;
	typedef logic [TAG_W-1:0]       tag_t;

	localparam status_t STATUS_OK   = 16'h0000;
	localparam status_t STATUS_FULL = 16'hffff;

	// unlisted opcode values behave as IGNORE
	typedef enum logic [3:0] {
		IGNORE = 4'd0,
		GET    = 4'd1,
		SETCUR = 4'd2,
		DELCUR = 4'd3
	} ht_op_e;

	typedef enum logic [2:0] {
		IDLE,
		LINE_ONE,
		LINE_TWO,
		DECIDE,
		LAUNCH,
		DRAIN
	} ht_state_e;

	// ------------------------------------------------------------
	// structs
	// ------------------------------------------------------------
	typedef struct packed {
		len_t      len;
		ptr_addr_t addr;
	} val_ptr_t;

	// a zero key marks an empty slot
	typedef struct packed {
		key_t     key;
		val_ptr_t cur;
		val_ptr_t next;
	} ht_entry_t;

	typedef struct packed {
		key_t       key;
		ht_op_e     opcode;
		tag_t       tag;
		len_t       value_len;
		line_addr_t hash1;
		line_addr_t hash2;
	} ht_req_t;

	typedef struct packed {
		status_t  status;
		val_ptr_t pointer;
		ht_op_e   opcode;
		tag_t     tag;
		key_t     key;
	} ht_resp_t;

	typedef struct packed {
		ptr_addr_t addr;
		len_t      size;
	} ht_free_t;

	typedef struct packed {
		logic      hit;
		logic      empty;
		logic      second_line;
		slot_idx_t slot;
		line_t     line;
	} ht_lookup_t;

	typedef struct packed {
		logic       do_write;
		line_addr_t line_addr;
		line_t      line;
		logic       do_free;
		ht_free_t   free_cmd;
		ht_resp_t   resp;
	} ht_plan_t;

endpackage

//--- src/ht_req_capture.sv
// request capture: accepts one request at a time and holds it until the sequencer is done
`timescale 1ns/1ps

module ht_req_capture (
	input  logic            clk,
	input  logic            rst_regd,
	input  ht_pkg::ht_req_t input_data,
	input  logic            input_valid,
	output logic            input_ready,
	input  logic            done,
	output ht_pkg::ht_req_t req,
	output logic            req_pending
);

	logic accept;

	// one request in flight, so a new one is only sampled when idle
	assign accept = input_valid && !req_pending;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			req_pending <= 1'b0;
			input_ready <= 1'b0;
		end else begin
			// ready is a single pulse in the cycle after sampling
			input_ready <= 1'b0;
			if (done) begin
				req_pending <= 1'b0;
			end else if (accept) begin
				req_pending <= 1'b1;
				input_ready <= 1'b1;
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (accept) begin
			req <= input_data;
		end
	end

endmodule

//--- src/ht_op_sequencer.sv
// operation sequencer FSM: paces line reads, allocation, decision, launch and drain
`timescale 1ns/1ps

module ht_op_sequencer (
	input  logic            clk,
	input  logic            rst_regd,
	input  ht_pkg::ht_req_t req,
	input  logic            req_pending,
	input  logic            rd_valid,
	output logic            rd_ready,
	input  logic            malloc_valid,
	output logic            malloc_ready,
	input  logic            wb_busy,
	output logic            line_take,
	output logic            decide,
	output logic            launch,
	output logic            done
);
	import ht_pkg::*;

	ht_state_e state;
	logic      need_lines;
	logic      need_malloc;
	logic      first_ok;
	logic      second_ok;

	always_comb begin
		need_malloc = (req.opcode == SETCUR);
		need_lines  = (req.opcode == GET) || (req.opcode == SETCUR) || (req.opcode == DELCUR);
	end

	// hash1 line, plus a pointer when the op allocates
	assign first_ok = (state == LINE_ONE) && rd_valid && (malloc_valid || !need_malloc);

	// skip the cycle where the first line's ready pulse is still out
	assign second_ok = (state == LINE_TWO) && rd_valid && !rd_ready;

	assign line_take = first_ok || second_ok;
	assign decide    = (state == DECIDE);
	assign launch    = (state == LAUNCH);
	assign done      = (state == DRAIN) && !wb_busy;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state        <= IDLE;
			rd_ready     <= 1'b0;
			malloc_ready <= 1'b0;
		end else begin
			rd_ready     <= 1'b0;
			malloc_ready <= 1'b0;
			case (state)
				IDLE: begin
					if (req_pending) begin
						state <= need_lines ? LINE_ONE : DECIDE;
					end
				end
				LINE_ONE: begin
					if (first_ok) begin
						rd_ready     <= 1'b1;
						malloc_ready <= need_malloc;
						state        <= LINE_TWO;
					end
				end
				LINE_TWO: begin
					if (second_ok) begin
						rd_ready <= 1'b1;
						state    <= DECIDE;
					end
				end
				DECIDE: begin
					state <= LAUNCH;
				end
				LAUNCH: begin
					state <= DRAIN;
				end
				DRAIN: begin
					// request ends once every output channel has handshaked
					if (!wb_busy) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- src/ht_bucket_scan.sv
// bucket scan: stores both candidate lines and locates the key or the first empty slot
`timescale 1ns/1ps

module ht_bucket_scan (
	input  logic               clk,
	input  logic               rst_regd,
	input  ht_pkg::line_t      rd_data,
	input  logic               line_take,
	input  ht_pkg::key_t       key,
	output ht_pkg::ht_lookup_t lookup
);
	import ht_pkg::*;

	line_t lines [2];
	// set after the hash1 line has been taken
	logic  second;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			second <= 1'b0;
		end else if (line_take) begin
			second <= !second;
		end
	end

	always_ff @(posedge clk) begin
		if (line_take) begin
			lines[second] <= rd_data;
		end
	end

	// priority: hash1 before hash2, low slot first
	always_comb begin
		ht_entry_t entry;
		logic      got_hit;
		logic      got_empty;
		logic      hit_sel;
		logic      empty_sel;
		logic      sel;
		slot_idx_t hit_slot;
		slot_idx_t empty_slot;

		got_hit    = 1'b0;
		got_empty  = 1'b0;
		hit_sel    = 1'b0;
		empty_sel  = 1'b0;
		hit_slot   = '0;
		empty_slot = '0;
		for (int l = 0; l < 2; l++) begin
			for (int s = 0; s < SLOTS_PER_LINE; s++) begin
				entry = lines[l][s*ENTRY_W +: ENTRY_W];
				if (!got_hit && entry.key == key) begin
					got_hit  = 1'b1;
					hit_sel  = 1'(l);
					hit_slot = slot_idx_t'(s);
				end
				if (!got_empty && entry.key == '0) begin
					got_empty  = 1'b1;
					empty_sel  = 1'(l);
					empty_slot = slot_idx_t'(s);
				end
			end
		end
		sel                = got_hit ? hit_sel : empty_sel;
		lookup.hit         = got_hit;
		lookup.empty       = !got_hit && got_empty;
		lookup.second_line = sel;
		lookup.slot        = got_hit ? hit_slot : empty_slot;
		lookup.line        = lines[sel];
	end

endmodule

//--- src/ht_entry_update.sv
// entry update: applies the opcode to the chosen slot and forms the write, free and response
`timescale 1ns/1ps

module ht_entry_update (
	input  logic                clk,
	input  logic                rst_regd,
	input  ht_pkg::ht_req_t     req,
	input  ht_pkg::ht_lookup_t  lookup,
	input  ht_pkg::ptr_addr_t   malloc_pointer,
	input  logic                malloc_take,
	input  logic                decide,
	output ht_pkg::ht_plan_t    plan
);
	import ht_pkg::*;

	ptr_addr_t alloc_addr;
	val_ptr_t  new_cur;
	ht_entry_t old_entry;
	ht_entry_t new_entry;
	ht_plan_t  nxt;

	// freed sizes are reported in whole 8-byte units
	function automatic len_t round8(len_t len);
		return {len[LEN_W-1:3], 3'b000};
	endfunction

	always_ff @(posedge clk) begin
		if (malloc_take) begin
			alloc_addr <= malloc_pointer;
		end
	end

	assign new_cur = '{len: req.value_len, addr: alloc_addr};

	// ------------------------------------------------------------
	// operation rules
	// ------------------------------------------------------------
	always_comb begin
		old_entry = lookup.line[lookup.slot*ENTRY_W +: ENTRY_W];
		new_entry = old_entry;

		nxt                = '0;
		nxt.line_addr      = lookup.second_line ? req.hash2 : req.hash1;
		nxt.resp.status    = STATUS_OK;
		nxt.resp.opcode    = req.opcode;
		nxt.resp.tag       = req.tag;
		nxt.resp.key       = req.key;

		case (req.opcode)
			GET: begin
				if (lookup.hit) begin
					nxt.resp.pointer = old_entry.cur;
				end
			end
			SETCUR: begin
				if (lookup.hit) begin
					new_entry.cur    = new_cur;
					nxt.do_write     = 1'b1;
					nxt.resp.pointer = new_cur;
					if (old_entry.cur != '0) begin
						nxt.do_free           = 1'b1;
						nxt.free_cmd.addr     = old_entry.cur.addr;
						nxt.free_cmd.size     = round8(old_entry.cur.len);
					end
				end else if (lookup.empty) begin
					new_entry        = '{key: req.key, cur: new_cur, next: '0};
					nxt.do_write     = 1'b1;
					nxt.resp.pointer = new_cur;
				end else begin
					// both buckets taken, hand the fresh allocation back
					nxt.resp.status   = STATUS_FULL;
					nxt.do_free       = 1'b1;
					nxt.free_cmd.addr = alloc_addr;
					nxt.free_cmd.size = round8(req.value_len);
				end
			end
			DELCUR: begin
				if (lookup.hit) begin
					new_entry.cur = '0;
					nxt.do_write  = 1'b1;
					if (old_entry.cur != '0) begin
						nxt.do_free       = 1'b1;
						nxt.free_cmd.addr = old_entry.cur.addr;
						nxt.free_cmd.size = round8(old_entry.cur.len);
					end
				end
			end
			default: begin
				// IGNORE and unknown codes answer with the defaults
			end
		endcase

		nxt.line                                = lookup.line;
		nxt.line[lookup.slot*ENTRY_W +: ENTRY_W] = new_entry;
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			plan.do_write <= 1'b0;
			plan.do_free  <= 1'b0;
		end else if (decide) begin
			plan <= nxt;
		end
	end

endmodule

//--- src/ht_writeback.sv
// writeback: drives the response, free, line write and write command channels
`timescale 1ns/1ps

module ht_writeback (
	input  logic              clk,
	input  logic              rst_regd,
	input  logic              launch,
	input  ht_pkg::ht_plan_t  plan,
	output logic              wb_busy,
	output ht_pkg::ht_resp_t  out_data,
	output logic              out_valid,
	input  logic              out_ready,
	output ht_pkg::ht_free_t  free_data,
	output logic              free_valid,
	input  logic              free_ready,
	output ht_pkg::line_t     wr_data,
	output logic              wr_valid,
	input  logic              wr_ready,
	output logic [31:0]       wrcmd_data,
	output logic              wrcmd_valid,
	input  logic              wrcmd_ready
);

	assign wb_busy = out_valid || free_valid || wr_valid || wrcmd_valid;

	// each valid drops on its own handshake
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			out_valid   <= 1'b0;
			free_valid  <= 1'b0;
			wr_valid    <= 1'b0;
			wrcmd_valid <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (free_valid && free_ready) begin
				free_valid <= 1'b0;
			end
			if (wr_valid && wr_ready) begin
				wr_valid <= 1'b0;
			end
			if (wrcmd_valid && wrcmd_ready) begin
				wrcmd_valid <= 1'b0;
			end
			// launch only comes while every channel is idle
			if (launch) begin
				out_valid   <= 1'b1;
				free_valid  <= plan.do_free;
				wr_valid    <= plan.do_write;
				wrcmd_valid <= plan.do_write;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			out_data   <= plan.resp;
			free_data  <= plan.free_cmd;
			wr_data    <= plan.line;
			wrcmd_data <= 32'(plan.line_addr);
		end
	end

endmodule

//--- src/ht_write_top.sv
// hash-table write unit top: joins request capture, sequencer, scan, update and output side
`timescale 1ns/1ps

module ht_write_top (
	input  logic               clk,
	input  logic               rst_regd,

	input  ht_pkg::ht_req_t    input_data,
	input  logic               input_valid,
	output logic               input_ready,

	input  ht_pkg::line_t      rd_data,
	input  logic               rd_valid,
	output logic               rd_ready,

	input  ht_pkg::ptr_addr_t  malloc_pointer,
	input  logic               malloc_valid,
	output logic               malloc_ready,

	output ht_pkg::ht_resp_t   out_data,
	output logic               out_valid,
	input  logic               out_ready,

	output ht_pkg::ht_free_t   free_data,
	output logic               free_valid,
	input  logic               free_ready,

	output ht_pkg::line_t      wr_data,
	output logic               wr_valid,
	input  logic               wr_ready,

	output logic [31:0]        wrcmd_data,
	output logic               wrcmd_valid,
	input  logic               wrcmd_ready
);
	import ht_pkg::*;

	ht_req_t    req;
	logic       req_pending;
	logic       done;
	logic       line_take;
	logic       decide;
	logic       launch;
	logic       wb_busy;
	ht_lookup_t lookup;
	ht_plan_t   plan;

	ht_req_capture u_capture (
		.clk         (clk),
		.rst_regd    (rst_regd),
		.input_data  (input_data),
		.input_valid (input_valid),
		.input_ready (input_ready),
		.done        (done),
		.req         (req),
		.req_pending (req_pending)
	);

	ht_op_sequencer u_sequencer (
		.clk          (clk),
		.rst_regd     (rst_regd),
		.req          (req),
		.req_pending  (req_pending),
		.rd_valid     (rd_valid),
		.rd_ready     (rd_ready),
		.malloc_valid (malloc_valid),
		.malloc_ready (malloc_ready),
		.wb_busy      (wb_busy),
		.line_take    (line_take),
		.decide       (decide),
		.launch       (launch),
		.done         (done)
	);

	ht_bucket_scan u_scan (
		.clk       (clk),
		.rst_regd  (rst_regd),
		.rd_data   (rd_data),
		.line_take (line_take),
		.key       (req.key),
		.lookup    (lookup)
	);

	// the allocator pointer is still presented during the malloc_ready pulse
	ht_entry_update u_update (
		.clk            (clk),
		.rst_regd       (rst_regd),
		.req            (req),
		.lookup         (lookup),
		.malloc_pointer (malloc_pointer),
		.malloc_take    (malloc_ready),
		.decide         (decide),
		.plan           (plan)
	);

	ht_writeback u_writeback (
		.clk         (clk),
		.rst_regd    (rst_regd),
		.launch      (launch),
		.plan        (plan),
		.wb_busy     (wb_busy),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.free_data   (free_data),
		.free_valid  (free_valid),
		.free_ready  (free_ready),
		.wr_data     (wr_data),
		.wr_valid    (wr_valid),
		.wr_ready    (wr_ready),
		.wrcmd_data  (wrcmd_data),
		.wrcmd_valid (wrcmd_valid),
		.wrcmd_ready (wrcmd_ready)
	);

endmodule

//--- test/ht_mem_model.sv
// bucket-line memory model that serves the hash1 and hash2 lines per request and applies line writes
`timescale 1ns/1ps

module ht_mem_model (
	input  logic            clk,
	input  ht_pkg::ht_req_t input_data,
	input  logic            input_valid,
	input  logic            input_ready,
	output ht_pkg::line_t   rd_data,
	output logic            rd_valid,
	input  logic            rd_ready,
	input  ht_pkg::line_t   wr_data,
	input  logic            wr_valid,
	input  logic            wr_ready,
	input  logic [31:0]     wrcmd_data,
	input  logic            wrcmd_valid,
	input  logic            wrcmd_ready,
	output int              read_count,
	output int              write_count
);
	import ht_pkg::*;

	// only the low line addresses are modelled
	localparam int DEPTH = 64;

	line_t      mem [DEPTH];
	line_addr_t second_addr;
	logic       on_second;

	initial begin
		rd_valid    = 1'b0;
		rd_data     = '0;
		on_second   = 1'b0;
		second_addr = '0;
		read_count  = 0;
		write_count = 0;
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	function automatic line_t peek(int addr);
		return mem[addr];
	endfunction

	task automatic poke(int addr, line_t line);
		mem[addr] = line;
	endtask

	// sample on the edge and update a little later
	always @(posedge clk) begin : mem_step
		logic    start;
		logic    claim;
		logic    take;
		logic    write;
		ht_req_t r;
		line_t   wline;
		int      waddr;

		r     = input_data;
		start = input_valid && input_ready &&
			(r.opcode == GET || r.opcode == SETCUR || r.opcode == DELCUR);
		claim = rd_ready;
		take  = rd_valid && rd_ready;
		write = wr_valid && wr_ready && wrcmd_valid && wrcmd_ready;
		wline = wr_data;
		waddr = int'(wrcmd_data);
		#1;
		// a write lands before any later read of the same line
		if (write) begin
			mem[waddr] = wline;
			write_count++;
		end
		// every ready pulse counts as a read, with or without a line on offer
		if (claim) begin
			read_count++;
		end
		if (take) begin
			if (!on_second) begin
				on_second = 1'b1;
				rd_data   = mem[second_addr];
			end else begin
				on_second = 1'b0;
				rd_valid  = 1'b0;
			end
		end
		if (start) begin
			on_second   = 1'b0;
			rd_valid    = 1'b1;
			rd_data     = mem[r.hash1];
			second_addr = r.hash2;
		end
	end

endmodule

//--- test/ht_write_tb.sv
// testbench for the hash-table write unit with directed requests against a bucket-line memory
`timescale 1ns/1ps

module ht_write_tb;
	import ht_pkg::*;

	localparam time        PERIOD     = 100ns;
	localparam int         RST_CYCLES = 8;
	localparam int         NUM_REQS   = 11;
	// generous bound for one request under random stalls
	localparam int         REQ_CYCLES = 200;
	localparam line_addr_t H1_A       = 21'd10;
	localparam line_addr_t H2_A       = 21'd20;
	localparam line_addr_t H1_B       = 21'd30;
	localparam line_addr_t H2_B       = 21'd31;

	logic        clk = 1'b0;
	logic        rst_regd;
	ht_req_t     input_data;
	logic        input_valid;
	logic        input_ready;
	line_t       rd_data;
	logic        rd_valid;
	logic        rd_ready;
	ptr_addr_t   malloc_pointer;
	logic        malloc_valid;
	logic        malloc_ready;
	ht_resp_t    out_data;
	logic        out_valid;
	logic        out_ready;
	ht_free_t    free_data;
	logic        free_valid;
	logic        free_ready;
	line_t       wr_data;
	logic        wr_valid;
	logic        wr_ready;
	logic [31:0] wrcmd_data;
	logic        wrcmd_valid;
	logic        wrcmd_ready;

	logic        backpressure;
	int          read_count;
	int          write_count;
	int          resp_count = 0;
	int          alloc_count = 0;
	ht_resp_t    last_resp;
	ht_free_t    free_q[$];
	int          r0;
	int          w0;
	int          f0;
	int          seed_ret;
	key_t        key_a;
	val_ptr_t    ptr_a;
	key_t        key_b;
	val_ptr_t    ptr_b;

	always #(PERIOD / 2) clk = ~clk;

	ht_write_top UUT (
		.clk            (clk),
		.rst_regd       (rst_regd),
		.input_data     (input_data),
		.input_valid    (input_valid),
		.input_ready    (input_ready),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid),
		.rd_ready       (rd_ready),
		.malloc_pointer (malloc_pointer),
		.malloc_valid   (malloc_valid),
		.malloc_ready   (malloc_ready),
		.out_data       (out_data),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.free_data      (free_data),
		.free_valid     (free_valid),
		.free_ready     (free_ready),
		.wr_data        (wr_data),
		.wr_valid       (wr_valid),
		.wr_ready       (wr_ready),
		.wrcmd_data     (wrcmd_data),
		.wrcmd_valid    (wrcmd_valid),
		.wrcmd_ready    (wrcmd_ready)
	);

	ht_mem_model u_mem (
		.clk         (clk),
		.input_data  (input_data),
		.input_valid (input_valid),
		.input_ready (input_ready),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.rd_ready    (rd_ready),
		.wr_data     (wr_data),
		.wr_valid    (wr_valid),
		.wr_ready    (wr_ready),
		.wrcmd_data  (wrcmd_data),
		.wrcmd_valid (wrcmd_valid),
		.wrcmd_ready (wrcmd_ready),
		.read_count  (read_count),
		.write_count (write_count)
	);

	// ------------------------------------------------------------
	// stimulus sources and output monitor
	// ------------------------------------------------------------
	function automatic ptr_addr_t new_alloc();
		// 8-byte aligned and never zero
		return (ptr_addr_t'($urandom) & 32'hffff_fff8) | 32'h0000_1000;
	endfunction

	always @(posedge clk) begin
		#1;
		if (backpressure) begin
			out_ready  = 1'($urandom);
			free_ready = 1'($urandom);
			wr_ready   = 1'($urandom);
		end else begin
			out_ready  = 1'b1;
			free_ready = 1'b1;
			wr_ready   = 1'b1;
		end
		wrcmd_ready = wr_ready;
	end

	// a fresh address once the current one is consumed
	always @(posedge clk) begin
		if (malloc_ready) begin
			#1;
			malloc_pointer = new_alloc();
		end
	end

	always @(posedge clk) begin
		if (out_valid && out_ready) begin
			last_resp = out_data;
			resp_count++;
		end
		if (free_valid && free_ready) begin
			free_q.push_back(free_data);
		end
		if (malloc_valid && malloc_ready) begin
			alloc_count++;
		end
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_resp(string name, ht_resp_t got, ht_resp_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_free(string name, ht_free_t got, ht_free_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_line(string name, line_t got, line_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	// ------------------------------------------------------------
	// expected values
	// ------------------------------------------------------------
	function automatic key_t rand_key();
		return {$urandom, $urandom} | 64'h1;
	endfunction

	function automatic tag_t rand_tag();
		return tag_t'({$urandom, $urandom, $urandom});
	endfunction

	function automatic val_ptr_t val_ptr(len_t len, ptr_addr_t addr);
		return {len, addr};
	endfunction

	function automatic ht_entry_t entry_of(key_t key, val_ptr_t cur);
		return {key, cur, 48'h0};
	endfunction

	function automatic ht_entry_t rand_entry();
		return entry_of(rand_key(), val_ptr(len_t'($urandom), new_alloc()));
	endfunction

	// slot s sits at bit s*ENTRY_W and the top bits stay zero
	function automatic line_t make_line(ht_entry_t e0, ht_entry_t e1, ht_entry_t e2);
		line_t l;
		l                          = '0;
		l[0 +: ENTRY_W]            = e0;
		l[ENTRY_W +: ENTRY_W]      = e1;
		l[2 * ENTRY_W +: ENTRY_W]  = e2;
		return l;
	endfunction

	function automatic ht_resp_t exp_resp(status_t st, val_ptr_t p, ht_op_e op, tag_t tag,
			key_t key);
		return {st, p, op, tag, key};
	endfunction

	function automatic ht_free_t exp_free(val_ptr_t p);
		return {p.addr, p.len & 16'hfff8};
	endfunction

	// ------------------------------------------------------------
	// request driver
	// ------------------------------------------------------------
	task automatic mark_counts();
		r0 = read_count;
		w0 = write_count;
		f0 = free_q.size();
	endtask

	task automatic check_effects(int reads, int writes, int frees);
		check_count("line reads", read_count - r0, reads);
		check_count("line writes", write_count - w0, writes);
		check_count("frees", free_q.size() - f0, frees);
	endtask

	// returns once every output channel of the request has handshaked
	task automatic run_req(ht_op_e op, key_t key, tag_t tag, len_t len, line_addr_t h1,
			line_addr_t h2, output ht_resp_t resp);
		int n;
		int a;
		n           = resp_count;
		a           = alloc_count;
		input_data  = {key, op, tag, len, h1, h2};
		input_valid = 1'b1;
		do begin
			@(posedge clk);
		end while (!input_ready);
		#1;
		input_valid = 1'b0;
		while (resp_count == n) begin
			@(posedge clk);
			#2;
		end
		while (out_valid || free_valid || wr_valid || wrcmd_valid) begin
			@(posedge clk);
			#2;
		end
		resp = last_resp;
		// only SETCUR draws one address from the allocator
		check_count("malloc takes", alloc_count - a, (op == SETCUR) ? 1 : 0);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_ignore();
		key_t     k;
		tag_t     t;
		ht_resp_t r;
		k = rand_key();
		t = rand_tag();
		mark_counts();
		run_req(IGNORE, k, t, 16'h0040, 21'd5, 21'd6, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, '0, IGNORE, t, k));
		check_effects(0, 0, 0);
	endtask

	task automatic test_set_new();
		tag_t     t;
		ht_resp_t r;
		key_a = rand_key();
		t     = rand_tag();
		ptr_a = val_ptr(16'h0123, malloc_pointer);
		mark_counts();
		run_req(SETCUR, key_a, t, ptr_a.len, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, ptr_a, SETCUR, t, key_a));
		check_effects(2, 1, 0);
		check_line("mem[hash1]", u_mem.peek(H1_A), make_line(entry_of(key_a, ptr_a), '0, '0));
		check_line("mem[hash2]", u_mem.peek(H2_A), '0);
	endtask

	task automatic test_set_again();
		tag_t     t;
		val_ptr_t old;
		ht_resp_t r;
		t     = rand_tag();
		old   = ptr_a;
		ptr_a = val_ptr(16'h0057, malloc_pointer);
		mark_counts();
		run_req(SETCUR, key_a, t, ptr_a.len, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, ptr_a, SETCUR, t, key_a));
		check_effects(2, 1, 1);
		check_free("free_data", free_q[f0], exp_free(old));
		check_line("mem[hash1]", u_mem.peek(H1_A), make_line(entry_of(key_a, ptr_a), '0, '0));
	endtask

	task automatic test_get();
		key_t     k;
		tag_t     t;
		ht_resp_t r;
		t = rand_tag();
		mark_counts();
		run_req(GET, key_a, t, '0, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, ptr_a, GET, t, key_a));
		check_effects(2, 0, 0);
		k = rand_key();
		mark_counts();
		run_req(GET, k, t, '0, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, '0, GET, t, k));
		check_effects(2, 0, 0);
		// key only in its hash2 line behind a full hash1 line
		key_b = rand_key();
		ptr_b = val_ptr(16'h0208, new_alloc());
		u_mem.poke(H1_B, make_line(rand_entry(), rand_entry(), rand_entry()));
		u_mem.poke(H2_B, make_line('0, entry_of(key_b, ptr_b), '0));
		mark_counts();
		run_req(GET, key_b, t, '0, H1_B, H2_B, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, ptr_b, GET, t, key_b));
		check_effects(2, 0, 0);
	endtask

	task automatic test_delcur();
		key_t     k;
		tag_t     t;
		ht_resp_t r;
		t = rand_tag();
		mark_counts();
		run_req(DELCUR, key_a, t, '0, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, '0, DELCUR, t, key_a));
		check_effects(2, 1, 1);
		check_free("free_data", free_q[f0], exp_free(ptr_a));
		check_line("mem[hash1]", u_mem.peek(H1_A), make_line(entry_of(key_a, '0), '0, '0));
		mark_counts();
		run_req(GET, key_a, t, '0, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, '0, GET, t, key_a));
		check_effects(2, 0, 0);
		k = rand_key();
		mark_counts();
		run_req(DELCUR, k, t, '0, H1_A, H2_A, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, '0, DELCUR, t, k));
		check_effects(2, 0, 0);
	endtask

	task automatic test_full();
		key_t      k;
		tag_t      t;
		ptr_addr_t a;
		line_t     l1;
		line_t     l2;
		val_ptr_t  p;
		ht_resp_t  r;
		backpressure = 1'b1;
		l1 = make_line(rand_entry(), rand_entry(), rand_entry());
		l2 = make_line(rand_entry(), rand_entry(), rand_entry());
		u_mem.poke(40, l1);
		u_mem.poke(41, l2);
		k = rand_key();
		t = rand_tag();
		a = malloc_pointer;
		mark_counts();
		run_req(SETCUR, k, t, 16'h00ff, 21'd40, 21'd41, r);
		check_resp("out_data", r, exp_resp(STATUS_FULL, '0, SETCUR, t, k));
		check_effects(2, 0, 1);
		check_free("free_data", free_q[f0], exp_free(val_ptr(16'h00ff, a)));
		check_line("mem[hash1]", u_mem.peek(40), l1);
		check_line("mem[hash2]", u_mem.peek(41), l2);
		// hit in the hash2 line is written back there
		l1 = u_mem.peek(H1_B);
		p  = val_ptr(16'h0031, malloc_pointer);
		mark_counts();
		run_req(SETCUR, key_b, t, p.len, H1_B, H2_B, r);
		check_resp("out_data", r, exp_resp(STATUS_OK, p, SETCUR, t, key_b));
		check_effects(2, 1, 1);
		check_free("free_data", free_q[f0], exp_free(ptr_b));
		check_line("mem[hash1]", u_mem.peek(H1_B), l1);
		check_line("mem[hash2]", u_mem.peek(H2_B), make_line('0, entry_of(key_b, p), '0));
		backpressure = 1'b0;
	endtask

	// ------------------------------------------------------------
	// run control
	// ------------------------------------------------------------
	initial begin
		#((RST_CYCLES + NUM_REQS * REQ_CYCLES) * PERIOD);
		$display("watchdog expired, a request never completed");
		stop_on_error();
	end

	initial begin
		seed_ret       = $urandom(32'hc635);
		rst_regd       = 1'b1;
		input_data     = '0;
		input_valid    = 1'b0;
		malloc_valid   = 1'b1;
		malloc_pointer = new_alloc();
		out_ready      = 1'b1;
		free_ready     = 1'b1;
		wr_ready       = 1'b1;
		wrcmd_ready    = 1'b1;
		backpressure   = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_regd = 1'b0;
		check_count("ready and valid outputs after reset",
			int'({input_ready, rd_ready, malloc_ready, out_valid, free_valid, wr_valid,
			wrcmd_valid}), 0);
		@(posedge clk);
		#1;
		test_ignore();
		test_set_new();
		test_set_again();
		test_get();
		test_delcur();
		test_full();
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- filelist.f
src/ht_pkg.sv
src/ht_req_capture.sv
src/ht_op_sequencer.sv
src/ht_bucket_scan.sv
src/ht_entry_update.sv
src/ht_writeback.sv
src/ht_write_top.sv
test/ht_mem_model.sv
test/ht_write_tb.sv
